// ==== rtl/sw_cfg_pkg.sv ====
package sw_cfg_pkg;

    localparam int data_w = 4;
    localparam int fifo_depth = 8;
    // Wide enough to hold fifo_depth itself
    localparam int cnt_w = 4;
    localparam int n_vc = 2;
    localparam int n_dest = 2;
    localparam int n_fifo = 5;

    // Bit order of the pause and error vectors
    localparam int fifo_mf = 0;
    localparam int fifo_v0 = 1;
    localparam int fifo_v1 = 2;
    localparam int fifo_d0 = 3;
    localparam int fifo_d1 = 4;

    typedef logic [data_w-1:0] dword_t;

    // Header bits sit above the data
    typedef struct packed {
        logic   vc;
        logic   dest;
        dword_t data;
    } flit_t;

endpackage

// ==== rtl/sw_ctrl_pkg.sv ====
package sw_ctrl_pkg;

    typedef enum logic [2:0] {
        st_reset  = 3'd0,
        st_init   = 3'd1,
        st_idle   = 3'd2,
        st_active = 3'd3,
        st_error  = 3'd4
    } ctrl_state_t;

endpackage

// ==== rtl/threshold_fifo.sv ====
`timescale 1ns/1ps

module threshold_fifo #(
    parameter type payload_t = sw_cfg_pkg::dword_t,
    parameter int  depth     = sw_cfg_pkg::fifo_depth
) (
    input  logic                         clk,
    input  logic                         reset_L,
    input  logic                         push,
    input  payload_t                     push_data,
    input  logic                         pop,
    output payload_t                     head,
    output logic                         empty,
    output logic                         full,
    output logic [sw_cfg_pkg::cnt_w-1:0] count,
    input  logic [sw_cfg_pkg::cnt_w-1:0] hi_thresh,
    output logic                         almost_full,
    output logic                         overflow
);
    import sw_cfg_pkg::*;

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    payload_t         mem [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic             do_push;
    logic             do_pop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        return (p == ptr_w'(depth - 1)) ? '0 : p + ptr_w'(1);
    endfunction

    assign empty = (count == '0);
    assign full = (count == cnt_w'(depth));
    assign almost_full = (count >= hi_thresh);
    assign head = mem[rd_ptr];

    // A pop frees its slot in the same cycle, so full still takes a push
    assign do_pop = pop && !empty;
    assign do_push = push && (!full || do_pop);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + cnt_w'(1);
                2'b01:   count <= count - cnt_w'(1);
                default: count <= count;
            endcase
            // Dropped word
            overflow <= push && !do_push;
        end
    end

    // Clients check empty before they pop
    assert property (@(posedge clk) disable iff (!reset_L) pop |-> !empty)
        else $error("pop on empty FIFO");

    assert property (@(posedge clk) disable iff (!reset_L) count <= cnt_w'(depth))
        else $error("FIFO count above depth");

endmodule

// ==== rtl/vc_router.sv ====
`timescale 1ns/1ps

module vc_router (
    input  logic                        clk,
    input  logic                        reset_L,
    input  logic                        in_req,
    input  sw_cfg_pkg::flit_t           in_flit,
    output logic                        in_ack,
    output logic                        mf_push,
    output sw_cfg_pkg::flit_t           mf_push_data,
    input  sw_cfg_pkg::flit_t           mf_head,
    input  logic                        mf_empty,
    output logic                        mf_pop,
    output logic [sw_cfg_pkg::n_vc-1:0] vc_push,
    output sw_cfg_pkg::flit_t           vc_push_data,
    input  logic [sw_cfg_pkg::n_vc-1:0] vc_almost_full
);
    import sw_cfg_pkg::*;

    typedef enum logic {
        in_wait_req,
        in_wait_drop
    } in_state_t;

    in_state_t in_state;

    // Flit lands in the main FIFO on the edge that raises in_ack
    assign mf_push = (in_state == in_wait_req) && in_req;
    assign mf_push_data = in_flit;
    assign in_ack = (in_state == in_wait_drop);

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            in_state <= in_wait_req;
        end else begin
            case (in_state)
                in_wait_req: begin
                    if (in_req) begin
                        in_state <= in_wait_drop;
                    end
                end
                in_wait_drop: begin
                    if (!in_req) begin
                        in_state <= in_wait_req;
                    end
                end
            endcase
        end
    end

    // Head moves only while its channel is below the high mark
    assign mf_pop = !mf_empty && !vc_almost_full[mf_head.vc];
    assign vc_push_data = mf_head;

    always_comb begin
        for (int v = 0; v < n_vc; v++) begin
            vc_push[v] = mf_pop && (int'(mf_head.vc) == v);
        end
    end

    assert property (@(posedge clk) disable iff (!reset_L) $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without in_req");

endmodule

// ==== rtl/vc_arbiter.sv ====
`timescale 1ns/1ps

module vc_arbiter (
    input  logic                          clk,
    input  logic                          reset_L,
    input  sw_cfg_pkg::flit_t             vc_head [sw_cfg_pkg::n_vc],
    input  logic [sw_cfg_pkg::n_vc-1:0]   vc_empty,
    output logic [sw_cfg_pkg::n_vc-1:0]   vc_pop,
    output logic [sw_cfg_pkg::n_dest-1:0] d_push,
    output sw_cfg_pkg::dword_t            d_push_data,
    input  logic [sw_cfg_pkg::n_dest-1:0] d_almost_full,
    input  sw_cfg_pkg::dword_t            d_head [sw_cfg_pkg::n_dest],
    input  logic [sw_cfg_pkg::n_dest-1:0] d_empty,
    output logic [sw_cfg_pkg::n_dest-1:0] d_pop,
    output logic [sw_cfg_pkg::n_dest-1:0] out_req,
    output sw_cfg_pkg::dword_t            out_data [sw_cfg_pkg::n_dest],
    input  logic [sw_cfg_pkg::n_dest-1:0] out_ack
);
    import sw_cfg_pkg::*;

    typedef enum logic [1:0] {
        eg_idle,
        eg_load,
        eg_req,
        eg_release
    } eg_state_t;

    eg_state_t       eg_state [n_dest];
    logic [n_vc-1:0] vc_ready;
    flit_t           sel;

    // Ready means a head with room in its destination
    always_comb begin
        for (int v = 0; v < n_vc; v++) begin
            vc_ready[v] = !vc_empty[v] && !d_almost_full[vc_head[v].dest];
        end
    end

    // Lowest ready channel wins, a blocked one is skipped
    always_comb begin
        vc_pop = '0;
        sel = vc_head[0];
        for (int v = n_vc - 1; v >= 0; v--) begin
            if (vc_ready[v]) begin
                vc_pop = '0;
                vc_pop[v] = 1'b1;
                sel = vc_head[v];
            end
        end
    end

    assign d_push_data = sel.data;

    always_comb begin
        for (int d = 0; d < n_dest; d++) begin
            d_push[d] = (|vc_pop) && (int'(sel.dest) == d);
            out_req[d] = (eg_state[d] == eg_req);
            d_pop[d] = (eg_state[d] == eg_req) && out_ack[d];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            for (int d = 0; d < n_dest; d++) begin
                eg_state[d] <= eg_idle;
            end
        end else begin
            for (int d = 0; d < n_dest; d++) begin
                case (eg_state[d])
                    eg_idle:    if (!d_empty[d]) eg_state[d] <= eg_load;
                    eg_load:    eg_state[d] <= eg_req;
                    eg_req:     if (out_ack[d]) eg_state[d] <= eg_release;
                    eg_release: if (!out_ack[d]) eg_state[d] <= eg_idle;
                endcase
            end
        end
    end

    // Head word held steady for the whole request
    always_ff @(posedge clk) begin
        for (int d = 0; d < n_dest; d++) begin
            if (eg_state[d] == eg_load) begin
                out_data[d] <= d_head[d];
            end
        end
    end

    assert property (@(posedge clk) disable iff (!reset_L) $onehot0(vc_pop))
        else $error("more than one channel popped");

endmodule

// ==== rtl/link_ctrl_fsm.sv ====
`timescale 1ns/1ps

module link_ctrl_fsm (
    input  logic                                                  clk,
    input  logic                                                  reset_L,
    input  logic                                                  init,
    input  logic [sw_cfg_pkg::cnt_w-1:0]                          mf_hi,
    input  logic [sw_cfg_pkg::cnt_w-1:0]                          mf_lo,
    input  logic [sw_cfg_pkg::n_vc-1:0][sw_cfg_pkg::cnt_w-1:0]    vc_hi,
    input  logic [sw_cfg_pkg::n_vc-1:0][sw_cfg_pkg::cnt_w-1:0]    vc_lo,
    input  logic [sw_cfg_pkg::n_dest-1:0][sw_cfg_pkg::cnt_w-1:0]  d_hi,
    input  logic [sw_cfg_pkg::n_dest-1:0][sw_cfg_pkg::cnt_w-1:0]  d_lo,
    input  logic [sw_cfg_pkg::n_fifo-1:0]                         fifo_empty,
    input  logic [sw_cfg_pkg::n_fifo-1:0]                         fifo_overflow,
    output logic [sw_cfg_pkg::n_fifo-1:0][sw_cfg_pkg::cnt_w-1:0]  thr_hi,
    output logic [sw_cfg_pkg::n_fifo-1:0][sw_cfg_pkg::cnt_w-1:0]  thr_lo,
    output logic                                                  idle_out,
    output logic                                                  active_out,
    output logic                                                  error_out,
    output logic [sw_cfg_pkg::n_fifo-1:0]                         error_full
);
    import sw_cfg_pkg::*;
    import sw_ctrl_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        all_empty;
    logic        any_overflow;

    assign all_empty = &fifo_empty;
    assign any_overflow = |fifo_overflow;

    assign idle_out = (state == st_idle);
    assign active_out = (state == st_active);
    assign error_out = (state == st_error);

    always_comb begin
        state_next = state;
        case (state)
            st_reset: state_next = st_init;
            st_init: begin
                if (init) begin
                    state_next = st_init;
                end else if (any_overflow) begin
                    state_next = st_error;
                end else if (all_empty) begin
                    state_next = st_idle;
                end else begin
                    state_next = st_active;
                end
            end
            st_idle: begin
                if (any_overflow) begin
                    state_next = st_error;
                end else if (!all_empty) begin
                    state_next = st_active;
                end
            end
            st_active: begin
                if (init) begin
                    state_next = st_init;
                end else if (any_overflow) begin
                    state_next = st_error;
                end else if (all_empty) begin
                    state_next = st_idle;
                end
            end
            // Only reset leaves error
            st_error: state_next = st_error;
            default:  state_next = st_reset;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_L) begin
            state <= st_reset;
            thr_hi <= '0;
            thr_lo <= '0;
            error_full <= '0;
        end else begin
            state <= state_next;
            if (state == st_init) begin
                thr_hi[fifo_mf] <= mf_hi;
                thr_lo[fifo_mf] <= mf_lo;
                for (int v = 0; v < n_vc; v++) begin
                    thr_hi[fifo_v0 + v] <= vc_hi[v];
                    thr_lo[fifo_v0 + v] <= vc_lo[v];
                end
                for (int d = 0; d < n_dest; d++) begin
                    thr_hi[fifo_d0 + d] <= d_hi[d];
                    thr_lo[fifo_d0 + d] <= d_lo[d];
                end
            end
            // Which FIFO dropped a word
            if (state_next == st_error && state != st_error) begin
                error_full <= fifo_overflow;
            end
        end
    end

endmodule

// ==== rtl/sw_top.sv ====
`timescale 1ns/1ps

module sw_top (
    input  logic                                                  clk,
    input  logic                                                  reset_L,
    input  logic                                                  init,
    input  logic [sw_cfg_pkg::cnt_w-1:0]                          mf_hi,
    input  logic [sw_cfg_pkg::cnt_w-1:0]                          mf_lo,
    input  logic [sw_cfg_pkg::n_vc-1:0][sw_cfg_pkg::cnt_w-1:0]    vc_hi,
    input  logic [sw_cfg_pkg::n_vc-1:0][sw_cfg_pkg::cnt_w-1:0]    vc_lo,
    input  logic [sw_cfg_pkg::n_dest-1:0][sw_cfg_pkg::cnt_w-1:0]  d_hi,
    input  logic [sw_cfg_pkg::n_dest-1:0][sw_cfg_pkg::cnt_w-1:0]  d_lo,
    input  logic                                                  in_req,
    input  sw_cfg_pkg::flit_t                                     in_flit,
    output logic                                                  in_ack,
    output logic [sw_cfg_pkg::n_dest-1:0]                         out_req,
    output sw_cfg_pkg::dword_t                        out_data [sw_cfg_pkg::n_dest],
    input  logic [sw_cfg_pkg::n_dest-1:0]                         out_ack,
    output logic                                                  idle_out,
    output logic                                                  active_out,
    output logic                                                  error_out,
    output logic [sw_cfg_pkg::n_fifo-1:0]                         error_full,
    output logic [sw_cfg_pkg::n_fifo-1:0]                         pause
);
    import sw_cfg_pkg::*;

    logic [n_fifo-1:0]            fifo_empty;
    logic [n_fifo-1:0]            fifo_overflow;
    logic [n_fifo-1:0][cnt_w-1:0] thr_hi;

    logic              mf_push;
    flit_t             mf_push_data;
    logic              mf_pop;
    flit_t             mf_head;
    logic [n_vc-1:0]   vc_push;
    flit_t             vc_push_data;
    logic [n_vc-1:0]   vc_pop;
    flit_t             vc_head [n_vc];
    logic [n_dest-1:0] d_push;
    dword_t            d_push_data;
    logic [n_dest-1:0] d_pop;
    dword_t            d_head [n_dest];

    threshold_fifo #(.payload_t(flit_t), .depth(fifo_depth)) u_mf_fifo (
        .clk         (clk),
        .reset_L     (reset_L),
        .push        (mf_push),
        .push_data   (mf_push_data),
        .pop         (mf_pop),
        .head        (mf_head),
        .empty       (fifo_empty[fifo_mf]),
        .full        (),
        .count       (),
        .hi_thresh   (thr_hi[fifo_mf]),
        .almost_full (pause[fifo_mf]),
        .overflow    (fifo_overflow[fifo_mf])
    );

    for (genvar v = 0; v < n_vc; v++) begin : g_vc
        threshold_fifo #(.payload_t(flit_t), .depth(fifo_depth)) u_vc_fifo (
            .clk         (clk),
            .reset_L     (reset_L),
            .push        (vc_push[v]),
            .push_data   (vc_push_data),
            .pop         (vc_pop[v]),
            .head        (vc_head[v]),
            .empty       (fifo_empty[fifo_v0 + v]),
            .full        (),
            .count       (),
            .hi_thresh   (thr_hi[fifo_v0 + v]),
            .almost_full (pause[fifo_v0 + v]),
            .overflow    (fifo_overflow[fifo_v0 + v])
        );
    end

    // Destination FIFOs hold data only
    for (genvar d = 0; d < n_dest; d++) begin : g_dest
        threshold_fifo #(.payload_t(dword_t), .depth(fifo_depth)) u_d_fifo (
            .clk         (clk),
            .reset_L     (reset_L),
            .push        (d_push[d]),
            .push_data   (d_push_data),
            .pop         (d_pop[d]),
            .head        (d_head[d]),
            .empty       (fifo_empty[fifo_d0 + d]),
            .full        (),
            .count       (),
            .hi_thresh   (thr_hi[fifo_d0 + d]),
            .almost_full (pause[fifo_d0 + d]),
            .overflow    (fifo_overflow[fifo_d0 + d])
        );
    end

    vc_router u_router (
        .clk            (clk),
        .reset_L        (reset_L),
        .in_req         (in_req),
        .in_flit        (in_flit),
        .in_ack         (in_ack),
        .mf_push        (mf_push),
        .mf_push_data   (mf_push_data),
        .mf_head        (mf_head),
        .mf_empty       (fifo_empty[fifo_mf]),
        .mf_pop         (mf_pop),
        .vc_push        (vc_push),
        .vc_push_data   (vc_push_data),
        .vc_almost_full (pause[fifo_v1:fifo_v0])
    );

    vc_arbiter u_arbiter (
        .clk           (clk),
        .reset_L       (reset_L),
        .vc_head       (vc_head),
        .vc_empty      (fifo_empty[fifo_v1:fifo_v0]),
        .vc_pop        (vc_pop),
        .d_push        (d_push),
        .d_push_data   (d_push_data),
        .d_almost_full (pause[fifo_d1:fifo_d0]),
        .d_head        (d_head),
        .d_empty       (fifo_empty[fifo_d1:fifo_d0]),
        .d_pop         (d_pop),
        .out_req       (out_req),
        .out_data      (out_data),
        .out_ack       (out_ack)
    );

    // Low thresholds are kept in the controller but not consumed here
    link_ctrl_fsm u_ctrl (
        .clk           (clk),
        .reset_L       (reset_L),
        .init          (init),
        .mf_hi         (mf_hi),
        .mf_lo         (mf_lo),
        .vc_hi         (vc_hi),
        .vc_lo         (vc_lo),
        .d_hi          (d_hi),
        .d_lo          (d_lo),
        .fifo_empty    (fifo_empty),
        .fifo_overflow (fifo_overflow),
        .thr_hi        (thr_hi),
        .thr_lo        (),
        .idle_out      (idle_out),
        .active_out    (active_out),
        .error_out     (error_out),
        .error_full    (error_full)
    );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real period_ns    = 10.0,
    parameter int  reset_cycles = 2
) (
    input  logic rst_req,
    output logic clk,
    output logic reset_L
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2.0) clk = ~clk;
        end
    end

    // Power-on reset, then one more for every request
    initial begin
        reset_L = 1'b0;
        forever begin
            repeat (reset_cycles) @(posedge clk);
            #1 reset_L = 1'b1;
            @(posedge rst_req);
            @(posedge clk);
            #1 reset_L = 1'b0;
        end
    end

endmodule

// ==== test/sw_tb.sv ====
`timescale 1ns/1ps

module sw_tb;
    import sw_cfg_pkg::*;

    typedef enum {
        k_route,
        k_fill,
        k_overflow,
        k_reinit
    } test_kind_t;

    typedef struct {
        test_kind_t       kind;
        logic [cnt_w-1:0] mf_hi;
        logic [cnt_w-1:0] vc_hi;
        logic [cnt_w-1:0] d_hi;
        logic [cnt_w-1:0] re_vc_hi;
        logic [cnt_w-1:0] re_d_hi;
        int               n_flits;
        bit               hold;
    } test_t;

    localparam int n_tests = 6;
    localparam int cycles_per_flit = 200;
    localparam int settle_cycles = 20;

    // Fill tests send every flit to vc 0, dest 0 with egress held
    test_t tests [n_tests] = '{
        '{k_route,    4'd6, 4'd4, 4'd4, 4'd0, 4'd0, 16, 1'b0},
        '{k_route,    4'd2, 4'd1, 4'd1, 4'd0, 4'd0, 16, 1'b0},
        '{k_fill,     4'd5, 4'd3, 4'd2, 4'd0, 4'd0, 9,  1'b1},
        '{k_fill,     4'd3, 4'd2, 4'd4, 4'd0, 4'd0, 12, 1'b1},
        '{k_overflow, 4'd8, 4'd2, 4'd2, 4'd0, 4'd0, 14, 1'b1},
        '{k_reinit,   4'd4, 4'd2, 4'd2, 4'd4, 4'd3, 10, 1'b1}
    };

    logic                         clk;
    logic                         reset_L;
    logic                         rst_req;
    logic                         init;
    logic [cnt_w-1:0]             mf_hi;
    logic [cnt_w-1:0]             mf_lo;
    logic [n_vc-1:0][cnt_w-1:0]   vc_hi;
    logic [n_vc-1:0][cnt_w-1:0]   vc_lo;
    logic [n_dest-1:0][cnt_w-1:0] d_hi;
    logic [n_dest-1:0][cnt_w-1:0] d_lo;
    logic                         in_req;
    flit_t                        in_flit;
    logic                         in_ack;
    logic [n_dest-1:0]            out_req;
    dword_t                       out_data [n_dest];
    logic [n_dest-1:0]            out_ack;
    logic                         idle_out;
    logic                         active_out;
    logic                         error_out;
    logic [n_fifo-1:0]            error_full;
    logic [n_fifo-1:0]            pause;

    logic [31:0] rng;
    logic        ack_hold;
    int          n_err;
    int          n_failed;
    // One queue per (vc, dest) pair at index vc * n_dest + dest
    dword_t      exp_q [n_vc * n_dest][$];

    tb_clk_gen #(.period_ns(10.0), .reset_cycles(2)) u_clk_gen (
        .rst_req (rst_req),
        .clk     (clk),
        .reset_L (reset_L)
    );

    sw_top u_dut (
        .clk        (clk),
        .reset_L    (reset_L),
        .init       (init),
        .mf_hi      (mf_hi),
        .mf_lo      (mf_lo),
        .vc_hi      (vc_hi),
        .vc_lo      (vc_lo),
        .d_hi       (d_hi),
        .d_lo       (d_lo),
        .in_req     (in_req),
        .in_flit    (in_flit),
        .in_ack     (in_ack),
        .out_req    (out_req),
        .out_data   (out_data),
        .out_ack    (out_ack),
        .idle_out   (idle_out),
        .active_out (active_out),
        .error_out  (error_out),
        .error_full (error_full),
        .pause      (pause)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic bit queues_empty();
        for (int q = 0; q < n_vc * n_dest; q++) begin
            if (exp_q[q].size() != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string name, input dword_t exp, input dword_t got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            n_err++;
        end
    endtask

    task automatic check_state(input logic [2:0] exp);
        logic [2:0] got;
        got = {idle_out, active_out, error_out};
        if (got !== exp) begin
            $display("ERR %0t idle/active/error expected %b got %b", $time, exp, got);
            n_err++;
        end
    endtask

    task automatic check_vec(input string name, input logic [n_fifo-1:0] exp,
                             input logic [n_fifo-1:0] got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %b got %b", $time, name, exp, got);
            n_err++;
        end
    endtask

    task automatic check_count(input string name, input logic [cnt_w-1:0] exp,
                               input logic [cnt_w-1:0] got);
        if (got !== exp) begin
            $display("ERR %0t %s expected %0d got %0d", $time, name, exp, got);
            n_err++;
        end
    endtask

    task automatic do_reset();
        rst_req = 1'b1;
        @(negedge reset_L);
        rst_req = 1'b0;
        @(posedge reset_L);
    endtask

    // Thresholds are taken while init holds the controller in its init state
    task automatic apply_cfg(input logic [cnt_w-1:0] mf, input logic [cnt_w-1:0] vc,
                             input logic [cnt_w-1:0] dst);
        mf_hi = mf;
        vc_hi = {n_vc{vc}};
        d_hi = {n_dest{dst}};
        init = 1'b1;
        repeat (3) tick();
        init = 1'b0;
        repeat (2) tick();
    endtask

    task automatic wait_ack(input logic level);
        do begin
            tick();
        end while (in_ack !== level);
    endtask

    task automatic send_flit(input flit_t f);
        in_flit = f;
        in_req = 1'b1;
        wait_ack(1'b1);
        in_req = 1'b0;
        wait_ack(1'b0);
    endtask

    // Match the word against the heads of both channels for this dest
    task automatic take_word(input int d, input dword_t got);
        int     v;
        dword_t exp;
        v = -1;
        for (int i = 0; i < n_vc; i++) begin
            if (v < 0 && exp_q[i * n_dest + d].size() > 0 && exp_q[i * n_dest + d][0] == got) begin
                v = i;
            end
        end
        for (int i = 0; i < n_vc; i++) begin
            if (v < 0 && exp_q[i * n_dest + d].size() > 0) begin
                v = i;
            end
        end
        if (v < 0) begin
            $display("unexpected word %h at egress %0d with nothing pending", got, d);
            n_err++;
        end else begin
            exp = exp_q[v * n_dest + d].pop_front();
            check_word($sformatf("out_data[%0d]", d), exp, got);
        end
    endtask

    task automatic check_fill(input int k, input int mf, input int vc, input int dst);
        int                d0;
        int                v0;
        int                m0;
        logic [n_fifo-1:0] exp_pause;
        // Destination fills first, then the channel, then the main FIFO
        d0 = (k < dst) ? k : dst;
        v0 = (k - d0 < vc) ? k - d0 : vc;
        m0 = k - d0 - v0;
        check_count("d0 count", cnt_w'(d0), u_dut.g_dest[0].u_d_fifo.count);
        check_count("v0 count", cnt_w'(v0), u_dut.g_vc[0].u_vc_fifo.count);
        check_count("mf count", cnt_w'(m0), u_dut.u_mf_fifo.count);
        exp_pause[fifo_mf] = (m0 >= mf);
        exp_pause[fifo_v0] = (v0 >= vc);
        exp_pause[fifo_v1] = (0 >= vc);
        exp_pause[fifo_d0] = (d0 >= dst);
        exp_pause[fifo_d1] = (0 >= dst);
        check_vec("pause", exp_pause, pause);
        check_state(3'b010);
        check_vec("error_full", '0, error_full);
    endtask

    task automatic run_route(input test_t t);
        flit_t  f;
        dword_t mask;
        int     seq [n_dest];
        rng = lcg_step(rng);
        mask = rng[27:24];
        for (int d = 0; d < n_dest; d++) begin
            seq[d] = 0;
        end
        for (int i = 0; i < t.n_flits; i++) begin
            rng = lcg_step(rng);
            f.vc = rng[31];
            f.dest = rng[30];
            // Data stays unique per dest so each word maps to one queue
            f.data = dword_t'(seq[f.dest]) ^ mask;
            seq[f.dest]++;
            exp_q[int'(f.vc) * n_dest + int'(f.dest)].push_back(f.data);
            send_flit(f);
            if (i == 0) begin
                check_state(3'b010);
            end
        end
        do begin
            tick();
        end while (!queues_empty());
        // Controller goes idle within two edges of the last pop
        repeat (3) tick();
        check_state(3'b100);
    endtask

    task automatic run_fill(input test_t t);
        flit_t             f;
        logic [n_fifo-1:0] mf_only;
        mf_only = '0;
        mf_only[fifo_mf] = 1'b1;
        for (int i = 0; i < t.n_flits; i++) begin
            rng = lcg_step(rng);
            f.vc = 1'b0;
            f.dest = 1'b0;
            f.data = rng[27:24];
            send_flit(f);
        end
        repeat (settle_cycles) tick();
        if (t.kind == k_overflow) begin
            check_state(3'b001);
            check_vec("error_full", mf_only, error_full);
            repeat (settle_cycles) tick();
            check_state(3'b001);
        end else begin
            check_fill(t.n_flits, int'(t.mf_hi), int'(t.vc_hi), int'(t.d_hi));
        end
        if (t.kind == k_reinit) begin
            apply_cfg(t.mf_hi, t.re_vc_hi, t.re_d_hi);
            repeat (settle_cycles) tick();
            check_fill(t.n_flits, int'(t.mf_hi), int'(t.re_vc_hi), int'(t.re_d_hi));
        end
    endtask

    task automatic run_test(input int idx, input test_t t);
        int err_start;
        err_start = n_err;
        for (int q = 0; q < n_vc * n_dest; q++) begin
            exp_q[q].delete();
        end
        do_reset();
        apply_cfg(t.mf_hi, t.vc_hi, t.d_hi);
        check_state(3'b100);
        check_vec("pause", '0, pause);
        ack_hold = t.hold;
        if (t.kind == k_route) begin
            run_route(t);
        end else begin
            run_fill(t);
        end
        if (n_err != err_start) begin
            n_failed++;
        end
        $display("test %0d %s: %s", idx, t.kind.name(), (n_err == err_start) ? "ok" : "FAIL");
    endtask

    // Egress responder answers each request unless held
    initial begin
        out_ack = '0;
        forever begin
            tick();
            for (int d = 0; d < n_dest; d++) begin
                if (out_req[d] && !out_ack[d] && !ack_hold) begin
                    take_word(d, out_data[d]);
                    out_ack[d] = 1'b1;
                end else if (!out_req[d] && out_ack[d]) begin
                    out_ack[d] = 1'b0;
                end
            end
        end
    end

    initial begin
        rst_req = 1'b0;
        init = 1'b0;
        mf_hi = '0;
        mf_lo = '0;
        vc_hi = '0;
        vc_lo = '0;
        d_hi = '0;
        d_lo = '0;
        in_req = 1'b0;
        in_flit = '0;
        ack_hold = 1'b0;
        rng = 32'h3772_1bb3;
        n_err = 0;
        n_failed = 0;
        wait (reset_L === 1'b1);
        tick();
        for (int i = 0; i < n_tests; i++) begin
            run_test(i, tests[i]);
        end
        $display("%0d tests run, %0d with errors, %0d errors in all", n_tests, n_failed, n_err);
        if (n_err == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        int limit;
        limit = 0;
        for (int i = 0; i < n_tests; i++) begin
            limit += cycles_per_flit * tests[i].n_flits;
        end
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== project.f ====
rtl/sw_cfg_pkg.sv
rtl/sw_ctrl_pkg.sv
rtl/threshold_fifo.sv
rtl/vc_router.sv
rtl/vc_arbiter.sv
rtl/link_ctrl_fsm.sv
rtl/sw_top.sv
test/tb_clk_gen.sv
test/sw_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sw_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
